// ==== issue_core_cfg.svh ====
`ifndef ISSUE_CORE_CFG_SVH
`define ISSUE_CORE_CFG_SVH

// Register data, immediates and addresses
`define ISSUE_DATA_W 32

// Physical register file
`define ISSUE_NUM_PREGS 32
`define ISSUE_PREG_W 5

// Reorder-buffer id carried with each op
`define ISSUE_ROB_W 6

// Default reservation station depth
`define ISSUE_RS_ENTS 8

`endif

// ==== issue_core_pkg.sv ====
`default_nettype none

package issue_core_pkg;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        LD  = 3'd6,
        ST  = 3'd7
    } t_uop;

    // Encoding 2'd3 is unused
    typedef enum logic [1:0] {
        OP_ZERO = 2'd0,
        OP_IMM  = 2'd1,
        OP_REG  = 2'd2
    } t_optype;

    typedef enum logic {
        FU_EXE = 1'b0,
        FU_MEM = 1'b1
    } t_fu;

    function automatic t_fu uop_to_fu(input t_uop uop);
        case (uop)
            LD, ST:  return FU_MEM;
            default: return FU_EXE;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== prf.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_core_cfg.svh"

module prf (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     wr_valid [2],
    input  logic [`ISSUE_PREG_W-1:0] wr_pdst  [2],
    input  logic [`ISSUE_DATA_W-1:0] wr_data  [2],

    input  logic                     alloc_valid,
    input  logic [`ISSUE_PREG_W-1:0] alloc_pdst,

    input  logic [`ISSUE_PREG_W-1:0] chk_psrc1,
    input  logic [`ISSUE_PREG_W-1:0] chk_psrc2,
    output logic                     chk_ready1,
    output logic                     chk_ready2,

    input  logic                     rd_en   [2],
    input  logic [`ISSUE_PREG_W-1:0] rd_addr [2],
    output logic [`ISSUE_DATA_W-1:0] rd_data [2]
);

logic [`ISSUE_DATA_W-1:0]    regs [`ISSUE_NUM_PREGS];
logic [`ISSUE_NUM_PREGS-1:0] ready_q;

// Scoreboard lookup, with this cycle's writes bypassed
always_comb begin
    chk_ready1 = ready_q[chk_psrc1];
    chk_ready2 = ready_q[chk_psrc2];
    for (int p = 0; p < 2; p++) begin
        if (wr_valid[p] && wr_pdst[p] == chk_psrc1) begin
            chk_ready1 = 1'b1;
        end
        if (wr_valid[p] && wr_pdst[p] == chk_psrc2) begin
            chk_ready2 = 1'b1;
        end
    end
end

// Registers come out of reset as zero and ready
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ready_q <= '1;
        for (int i = 0; i < `ISSUE_NUM_PREGS; i++) begin
            regs[i] <= '0;
        end
    end else begin
        for (int p = 0; p < 2; p++) begin
            if (wr_valid[p]) begin
                regs[wr_pdst[p]]    <= wr_data[p];
                ready_q[wr_pdst[p]] <= 1'b1;
            end
        end
        // New destination becomes pending
        if (alloc_valid) begin
            ready_q[alloc_pdst] <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
        if (rd_en[p]) begin
            rd_data[p] <= regs[rd_addr[p]];
        end
    end
end

endmodule

`default_nettype wire

// ==== rs_entry.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_core_cfg.svh"

module rs_entry
    import issue_core_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     alloc,
    input  t_uop                     disp_uop,
    input  t_optype                  disp_src1_type,
    input  t_optype                  disp_src2_type,
    input  logic [`ISSUE_PREG_W-1:0] disp_psrc1,
    input  logic [`ISSUE_PREG_W-1:0] disp_psrc2,
    input  logic [`ISSUE_DATA_W-1:0] disp_imm,
    input  logic [`ISSUE_PREG_W-1:0] disp_pdst,
    input  logic [`ISSUE_ROB_W-1:0]  disp_robid,
    input  logic                     disp_src1_ready,
    input  logic                     disp_src2_ready,

    input  logic                     wr_valid [2],
    input  logic [`ISSUE_PREG_W-1:0] wr_pdst  [2],

    input  logic                     gnt,

    output logic                     valid,
    output logic                     req,
    output t_uop                     e_uop,
    output t_optype                  e_src1_type,
    output t_optype                  e_src2_type,
    output logic [`ISSUE_PREG_W-1:0] e_psrc1,
    output logic [`ISSUE_PREG_W-1:0] e_psrc2,
    output logic [`ISSUE_DATA_W-1:0] e_imm,
    output logic [`ISSUE_PREG_W-1:0] e_pdst,
    output logic [`ISSUE_ROB_W-1:0]  e_robid
);

logic src1_rdy_q;
logic src2_rdy_q;
logic wake1;
logic wake2;

// Wakeup on a matching writeback
always_comb begin
    wake1 = 1'b0;
    wake2 = 1'b0;
    for (int p = 0; p < 2; p++) begin
        wake1 = wake1 | (wr_valid[p] && wr_pdst[p] == e_psrc1);
        wake2 = wake2 | (wr_valid[p] && wr_pdst[p] == e_psrc2);
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        valid      <= 1'b0;
        src1_rdy_q <= 1'b0;
        src2_rdy_q <= 1'b0;
    end else if (alloc) begin
        valid      <= 1'b1;
        // Non-register operands never wait
        src1_rdy_q <= (disp_src1_type != OP_REG) || disp_src1_ready;
        src2_rdy_q <= (disp_src2_type != OP_REG) || disp_src2_ready;
    end else begin
        if (gnt) begin
            valid <= 1'b0;
        end
        src1_rdy_q <= src1_rdy_q | wake1;
        src2_rdy_q <= src2_rdy_q | wake2;
    end
end

always_ff @(posedge clk) begin
    if (alloc) begin
        e_uop       <= disp_uop;
        e_src1_type <= disp_src1_type;
        e_src2_type <= disp_src2_type;
        e_psrc1     <= disp_psrc1;
        e_psrc2     <= disp_psrc2;
        e_imm       <= disp_imm;
        e_pdst      <= disp_pdst;
        e_robid     <= disp_robid;
    end
end

assign req = valid && src1_rdy_q && src2_rdy_q;

endmodule

`default_nettype wire

// ==== rs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_core_cfg.svh"

module rs
    import issue_core_pkg::*;
#(
    parameter int NUM_ENTS = `ISSUE_RS_ENTS
) (
    input  logic                     clk,
    input  logic                     rst_n,

    output logic                     rs_full,
    input  logic                     disp_valid,
    input  t_uop                     disp_uop,
    input  t_optype                  disp_src1_type,
    input  t_optype                  disp_src2_type,
    input  logic [`ISSUE_PREG_W-1:0] disp_psrc1,
    input  logic [`ISSUE_PREG_W-1:0] disp_psrc2,
    input  logic [`ISSUE_DATA_W-1:0] disp_imm,
    input  logic [`ISSUE_PREG_W-1:0] disp_pdst,
    input  logic [`ISSUE_ROB_W-1:0]  disp_robid,
    input  logic                     disp_src1_ready,
    input  logic                     disp_src2_ready,

    input  logic                     wr_valid [2],
    input  logic [`ISSUE_PREG_W-1:0] wr_pdst  [2],

    output logic                     rd_en   [2],
    output logic [`ISSUE_PREG_W-1:0] rd_addr [2],
    input  logic [`ISSUE_DATA_W-1:0] rd_data [2],

    output logic                     ex_iss,
    output logic                     mm_iss,
    output t_uop                     iss_uop,
    output logic [`ISSUE_PREG_W-1:0] iss_pdst,
    output logic [`ISSUE_ROB_W-1:0]  iss_robid,
    output logic [`ISSUE_DATA_W-1:0] iss_src1_val,
    output logic [`ISSUE_DATA_W-1:0] iss_src2_val
);

localparam int IDX_W = (NUM_ENTS > 1) ? $clog2(NUM_ENTS) : 1;

logic [NUM_ENTS-1:0]      ent_valid;
logic [NUM_ENTS-1:0]      ent_req;
logic [NUM_ENTS-1:0]      ent_alloc;
logic [NUM_ENTS-1:0]      ent_gnt;
t_uop                     e_uop       [NUM_ENTS];
t_optype                  e_src1_type [NUM_ENTS];
t_optype                  e_src2_type [NUM_ENTS];
logic [`ISSUE_PREG_W-1:0] e_psrc1     [NUM_ENTS];
logic [`ISSUE_PREG_W-1:0] e_psrc2     [NUM_ENTS];
logic [`ISSUE_DATA_W-1:0] e_imm       [NUM_ENTS];
logic [`ISSUE_PREG_W-1:0] e_pdst      [NUM_ENTS];
logic [`ISSUE_ROB_W-1:0]  e_robid     [NUM_ENTS];

logic [IDX_W-1:0]         alloc_idx;
logic [IDX_W-1:0]         sel_idx;
logic                     any_req;

// rs1 to rs2 staging
logic                     iss_q;
t_uop                     q_uop;
t_optype                  q_src1_type;
t_optype                  q_src2_type;
logic [`ISSUE_DATA_W-1:0] q_imm;
logic [`ISSUE_PREG_W-1:0] q_pdst;
logic [`ISSUE_ROB_W-1:0]  q_robid;

function automatic logic [`ISSUE_DATA_W-1:0] opsel(
    input t_optype                  optype,
    input logic [`ISSUE_DATA_W-1:0] imm,
    input logic [`ISSUE_DATA_W-1:0] reg_data
);
    case (optype)
        OP_REG:  return reg_data;
        OP_IMM:  return imm;
        default: return '0;
    endcase
endfunction

// Lowest free entry and lowest requester, scanned top down
always_comb begin
    alloc_idx = '0;
    sel_idx   = '0;
    any_req   = 1'b0;
    for (int i = NUM_ENTS - 1; i >= 0; i--) begin
        if (!ent_valid[i]) begin
            alloc_idx = IDX_W'(i);
        end
        if (ent_req[i]) begin
            sel_idx = IDX_W'(i);
            any_req = 1'b1;
        end
    end
end

assign rs_full = &ent_valid;

always_comb begin
    for (int i = 0; i < NUM_ENTS; i++) begin
        ent_alloc[i] = disp_valid && !rs_full && alloc_idx == IDX_W'(i);
        ent_gnt[i]   = any_req && sel_idx == IDX_W'(i);
    end
end

// Operand read issued in rs1
assign rd_en[0]   = any_req && e_src1_type[sel_idx] == OP_REG;
assign rd_addr[0] = e_psrc1[sel_idx];
assign rd_en[1]   = any_req && e_src2_type[sel_idx] == OP_REG;
assign rd_addr[1] = e_psrc2[sel_idx];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        iss_q <= 1'b0;
    end else begin
        iss_q <= any_req;
    end
end

always_ff @(posedge clk) begin
    if (any_req) begin
        q_uop       <= e_uop[sel_idx];
        q_src1_type <= e_src1_type[sel_idx];
        q_src2_type <= e_src2_type[sel_idx];
        q_imm       <= e_imm[sel_idx];
        q_pdst      <= e_pdst[sel_idx];
        q_robid     <= e_robid[sel_idx];
    end
end

assign iss_uop      = q_uop;
assign iss_pdst     = q_pdst;
assign iss_robid    = q_robid;
assign iss_src1_val = opsel(q_src1_type, q_imm, rd_data[0]);
assign iss_src2_val = opsel(q_src2_type, q_imm, rd_data[1]);
assign ex_iss       = iss_q && uop_to_fu(q_uop) == FU_EXE;
assign mm_iss       = iss_q && uop_to_fu(q_uop) == FU_MEM;

for (genvar i = 0; i < NUM_ENTS; i++) begin : g_ent
    rs_entry u_rs_entry (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc           (ent_alloc[i]),
        .disp_uop        (disp_uop),
        .disp_src1_type  (disp_src1_type),
        .disp_src2_type  (disp_src2_type),
        .disp_psrc1      (disp_psrc1),
        .disp_psrc2      (disp_psrc2),
        .disp_imm        (disp_imm),
        .disp_pdst       (disp_pdst),
        .disp_robid      (disp_robid),
        .disp_src1_ready (disp_src1_ready),
        .disp_src2_ready (disp_src2_ready),
        .wr_valid        (wr_valid),
        .wr_pdst         (wr_pdst),
        .gnt             (ent_gnt[i]),
        .valid           (ent_valid[i]),
        .req             (ent_req[i]),
        .e_uop           (e_uop[i]),
        .e_src1_type     (e_src1_type[i]),
        .e_src2_type     (e_src2_type[i]),
        .e_psrc1         (e_psrc1[i]),
        .e_psrc2         (e_psrc2[i]),
        .e_imm           (e_imm[i]),
        .e_pdst          (e_pdst[i]),
        .e_robid         (e_robid[i])
    );
end

endmodule

`default_nettype wire

// ==== alu_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_core_cfg.svh"

module alu_exec
    import issue_core_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     ex_iss,
    input  t_uop                     iss_uop,
    input  logic [`ISSUE_PREG_W-1:0] iss_pdst,
    input  logic [`ISSUE_DATA_W-1:0] iss_src1_val,
    input  logic [`ISSUE_DATA_W-1:0] iss_src2_val,

    output logic                     alu_wr_valid,
    output logic [`ISSUE_PREG_W-1:0] alu_wr_pdst,
    output logic [`ISSUE_DATA_W-1:0] alu_wr_data
);

logic [`ISSUE_DATA_W-1:0] result;

always_comb begin
    case (iss_uop)
        ADD:     result = iss_src1_val + iss_src2_val;
        SUB:     result = iss_src1_val - iss_src2_val;
        AND:     result = iss_src1_val & iss_src2_val;
        OR:      result = iss_src1_val | iss_src2_val;
        XOR:     result = iss_src1_val ^ iss_src2_val;
        // Shift amount from the low five bits only
        SLL:     result = iss_src1_val << iss_src2_val[4:0];
        default: result = '0;
    endcase
end

// Result goes back the same cycle it issues
assign alu_wr_valid = ex_iss;
assign alu_wr_pdst  = iss_pdst;
assign alu_wr_data  = result;

endmodule

`default_nettype wire

// ==== issue_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_core_cfg.svh"

module issue_core
    import issue_core_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     disp_valid,
    input  t_uop                     disp_uop,
    input  t_optype                  disp_src1_type,
    input  t_optype                  disp_src2_type,
    input  logic [`ISSUE_PREG_W-1:0] disp_psrc1,
    input  logic [`ISSUE_PREG_W-1:0] disp_psrc2,
    input  logic [`ISSUE_DATA_W-1:0] disp_imm,
    input  logic [`ISSUE_PREG_W-1:0] disp_pdst,
    input  logic [`ISSUE_ROB_W-1:0]  disp_robid,
    output logic                     rs_full,

    input  logic                     ext_wr_valid,
    input  logic [`ISSUE_PREG_W-1:0] ext_wr_pdst,
    input  logic [`ISSUE_DATA_W-1:0] ext_wr_data,

    output logic                     ex_iss,
    output logic                     mm_iss,
    output t_uop                     iss_uop,
    output logic [`ISSUE_PREG_W-1:0] iss_pdst,
    output logic [`ISSUE_ROB_W-1:0]  iss_robid,
    output logic [`ISSUE_DATA_W-1:0] iss_src1_val,
    output logic [`ISSUE_DATA_W-1:0] iss_src2_val,

    output logic                     alu_wr_valid,
    output logic [`ISSUE_PREG_W-1:0] alu_wr_pdst,
    output logic [`ISSUE_DATA_W-1:0] alu_wr_data
);

logic                     wr_valid [2];
logic [`ISSUE_PREG_W-1:0] wr_pdst  [2];
logic [`ISSUE_DATA_W-1:0] wr_data  [2];
logic                     rd_en    [2];
logic [`ISSUE_PREG_W-1:0] rd_addr  [2];
logic [`ISSUE_DATA_W-1:0] rd_data  [2];
logic                     src1_ready;
logic                     src2_ready;
logic                     alloc_valid;

// Port 0 is the ALU, port 1 the external load return
assign wr_valid[0] = alu_wr_valid;
assign wr_pdst[0]  = alu_wr_pdst;
assign wr_data[0]  = alu_wr_data;
assign wr_valid[1] = ext_wr_valid;
assign wr_pdst[1]  = ext_wr_pdst;
assign wr_data[1]  = ext_wr_data;

// Stores have no destination
assign alloc_valid = disp_valid && disp_uop != ST;

prf u_prf (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_valid    (wr_valid),
    .wr_pdst     (wr_pdst),
    .wr_data     (wr_data),
    .alloc_valid (alloc_valid),
    .alloc_pdst  (disp_pdst),
    .chk_psrc1   (disp_psrc1),
    .chk_psrc2   (disp_psrc2),
    .chk_ready1  (src1_ready),
    .chk_ready2  (src2_ready),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
);

rs #(
    .NUM_ENTS (`ISSUE_RS_ENTS)
) u_rs (
    .clk             (clk),
    .rst_n           (rst_n),
    .rs_full         (rs_full),
    .disp_valid      (disp_valid),
    .disp_uop        (disp_uop),
    .disp_src1_type  (disp_src1_type),
    .disp_src2_type  (disp_src2_type),
    .disp_psrc1      (disp_psrc1),
    .disp_psrc2      (disp_psrc2),
    .disp_imm        (disp_imm),
    .disp_pdst       (disp_pdst),
    .disp_robid      (disp_robid),
    .disp_src1_ready (src1_ready),
    .disp_src2_ready (src2_ready),
    .wr_valid        (wr_valid),
    .wr_pdst         (wr_pdst),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .ex_iss          (ex_iss),
    .mm_iss          (mm_iss),
    .iss_uop         (iss_uop),
    .iss_pdst        (iss_pdst),
    .iss_robid       (iss_robid),
    .iss_src1_val    (iss_src1_val),
    .iss_src2_val    (iss_src2_val)
);

alu_exec u_alu_exec (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_iss       (ex_iss),
    .iss_uop      (iss_uop),
    .iss_pdst     (iss_pdst),
    .iss_src1_val (iss_src1_val),
    .iss_src2_val (iss_src2_val),
    .alu_wr_valid (alu_wr_valid),
    .alu_wr_pdst  (alu_wr_pdst),
    .alu_wr_data  (alu_wr_data)
);

endmodule

`default_nettype wire

// ==== issue_core_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_core_cfg.svh"

module issue_core_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      disp_valid,
    input logic                      rs_full,
    input logic [`ISSUE_RS_ENTS-1:0] ent_valid,
    input logic [`ISSUE_RS_ENTS-1:0] ent_gnt
);

// A grant always leaves room for the next dispatch
a_gnt_not_full: assert property (@(posedge clk) disable iff (!rst_n) |ent_gnt |=> !rs_full)
    else $error("station still full after a grant");

a_no_disp_full: assert property (@(posedge clk) disable iff (!rst_n) !(disp_valid && rs_full))
    else $error("dispatch while the station is full");

a_gnt_frees: assert property (@(posedge clk) disable iff (!rst_n)
    |ent_gnt |=> (ent_valid & $past(ent_gnt)) == '0)
    else $error("granted entry still valid after the grant");

endmodule

bind rs issue_core_assert u_issue_core_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .disp_valid (disp_valid),
    .rs_full    (rs_full),
    .ent_valid  (ent_valid),
    .ent_gnt    (ent_gnt)
);

`default_nettype wire

// ==== issue_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_core_cfg.svh"

module issue_core_tb
    import issue_core_pkg::*;
();

localparam int N_DISP    = 300;
localparam int CLK_NS    = 10;
localparam int WD_NS     = N_DISP * 40 * CLK_NS;
localparam int NUM_ROB   = 1 << `ISSUE_ROB_W;
localparam int PW        = `ISSUE_PREG_W;
localparam int RW        = `ISSUE_ROB_W;
localparam int MODE_IDLE = 0;
localparam int MODE_RAND = 1;
localparam int MODE_LOAD = 2;
localparam int MODE_DEP  = 3;

logic                     clk;
logic                     rst_n;
logic                     disp_valid;
t_uop                     disp_uop;
t_optype                  disp_src1_type;
t_optype                  disp_src2_type;
logic [`ISSUE_PREG_W-1:0] disp_psrc1;
logic [`ISSUE_PREG_W-1:0] disp_psrc2;
logic [`ISSUE_DATA_W-1:0] disp_imm;
logic [`ISSUE_PREG_W-1:0] disp_pdst;
logic [`ISSUE_ROB_W-1:0]  disp_robid;
logic                     rs_full;
logic                     ext_wr_valid;
logic [`ISSUE_PREG_W-1:0] ext_wr_pdst;
logic [`ISSUE_DATA_W-1:0] ext_wr_data;
logic                     ex_iss;
logic                     mm_iss;
t_uop                     iss_uop;
logic [`ISSUE_PREG_W-1:0] iss_pdst;
logic [`ISSUE_ROB_W-1:0]  iss_robid;
logic [`ISSUE_DATA_W-1:0] iss_src1_val;
logic [`ISSUE_DATA_W-1:0] iss_src2_val;
logic                     alu_wr_valid;
logic [`ISSUE_PREG_W-1:0] alu_wr_pdst;
logic [`ISSUE_DATA_W-1:0] alu_wr_data;

// Reference model of the register file
logic [`ISSUE_DATA_W-1:0] mval    [`ISSUE_NUM_PREGS];
bit                       mpend   [`ISSUE_NUM_PREGS];
int                       readers [`ISSUE_NUM_PREGS];
logic [`ISSUE_PREG_W-1:0] free_q  [$];
logic [`ISSUE_PREG_W-1:0] live_q  [$];
logic [`ISSUE_PREG_W-1:0] held_q  [$];
// Loads waiting for their data
logic [`ISSUE_PREG_W-1:0] ld_pd   [$];
int                       ld_due  [$];
bit                       hold_loads;

// Ops in flight, by robid
bit                       r_busy [NUM_ROB];
t_uop                     r_uop  [NUM_ROB];
t_optype                  r_t1   [NUM_ROB];
t_optype                  r_t2   [NUM_ROB];
logic [`ISSUE_PREG_W-1:0] r_p1   [NUM_ROB];
logic [`ISSUE_PREG_W-1:0] r_p2   [NUM_ROB];
logic [`ISSUE_PREG_W-1:0] r_pd   [NUM_ROB];
logic [`ISSUE_DATA_W-1:0] r_imm  [NUM_ROB];

int                       in_flight;
int                       n_issued;
int                       cyc;
logic [31:0]              rng;

issue_core u_issue_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .disp_valid     (disp_valid),
    .disp_uop       (disp_uop),
    .disp_src1_type (disp_src1_type),
    .disp_src2_type (disp_src2_type),
    .disp_psrc1     (disp_psrc1),
    .disp_psrc2     (disp_psrc2),
    .disp_imm       (disp_imm),
    .disp_pdst      (disp_pdst),
    .disp_robid     (disp_robid),
    .rs_full        (rs_full),
    .ext_wr_valid   (ext_wr_valid),
    .ext_wr_pdst    (ext_wr_pdst),
    .ext_wr_data    (ext_wr_data),
    .ex_iss         (ex_iss),
    .mm_iss         (mm_iss),
    .iss_uop        (iss_uop),
    .iss_pdst       (iss_pdst),
    .iss_robid      (iss_robid),
    .iss_src1_val   (iss_src1_val),
    .iss_src2_val   (iss_src2_val),
    .alu_wr_valid   (alu_wr_valid),
    .alu_wr_pdst    (alu_wr_pdst),
    .alu_wr_data    (alu_wr_data)
);

initial clk = 1'b0;
always #(CLK_NS / 2) clk = ~clk;

function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

function automatic int rnd(input int n);
    return int'(rand32() % 32'(n));
endfunction

function automatic logic [`ISSUE_DATA_W-1:0] alu_ref(
    input t_uop                     u,
    input logic [`ISSUE_DATA_W-1:0] a,
    input logic [`ISSUE_DATA_W-1:0] b
);
    case (u)
        ADD:     return a + b;
        SUB:     return a - b;
        AND:     return a & b;
        OR:      return a | b;
        XOR:     return a ^ b;
        SLL:     return a << b[4:0];
        default: return '0;
    endcase
endfunction

function automatic logic [`ISSUE_DATA_W-1:0] operand(
    input t_optype                  t,
    input logic [`ISSUE_PREG_W-1:0] p,
    input logic [`ISSUE_DATA_W-1:0] imm
);
    if (t == OP_REG) begin
        return mval[p];
    end
    if (t == OP_IMM) begin
        return imm;
    end
    return '0;
endfunction

task automatic fail_now(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_uop(input string name, input t_uop got, input t_uop exp);
    if (got !== exp) begin
        fail_now($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_data(
    input string                    name,
    input logic [`ISSUE_DATA_W-1:0] got,
    input logic [`ISSUE_DATA_W-1:0] exp
);
    if (got !== exp) begin
        fail_now($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_preg(
    input string                    name,
    input logic [`ISSUE_PREG_W-1:0] got,
    input logic [`ISSUE_PREG_W-1:0] exp
);
    if (got !== exp) begin
        fail_now($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

// Free the oldest register that is written and no longer read
task automatic reclaim();
    for (int i = 0; i < live_q.size(); i++) begin
        if (!mpend[live_q[i]] && readers[live_q[i]] == 0) begin
            free_q.push_back(live_q[i]);
            live_q.delete(i);
            return;
        end
    end
endtask

task automatic build_op(input int mode, output bit ok);
    t_uop                     u;
    t_optype                  t1;
    t_optype                  t2;
    logic [`ISSUE_PREG_W-1:0] p1;
    logic [`ISSUE_PREG_W-1:0] p2;
    logic [`ISSUE_PREG_W-1:0] pd;
    logic [`ISSUE_ROB_W-1:0]  rb;
    ok = 1'b0;
    if (mode == MODE_RAND) begin
        u  = t_uop'(3'(rnd(8)));
        t1 = t_optype'(2'(rnd(3)));
        t2 = t_optype'(2'(rnd(3)));
    end else if (mode == MODE_LOAD) begin
        u  = LD;
        t1 = OP_IMM;
        t2 = OP_ZERO;
    end else begin
        u  = t_uop'(3'(rnd(6)));
        t1 = OP_REG;
        t2 = OP_IMM;
    end
    if (u != ST && free_q.size() == 0) begin
        reclaim();
    end
    if (u != ST && free_q.size() == 0) begin
        return;
    end
    if (live_q.size() == 0 && t1 == OP_REG) begin
        t1 = OP_IMM;
    end
    if (live_q.size() == 0 && t2 == OP_REG) begin
        t2 = OP_IMM;
    end
    p1 = PW'(rnd(`ISSUE_NUM_PREGS));
    p2 = PW'(rnd(`ISSUE_NUM_PREGS));
    pd = PW'(rnd(`ISSUE_NUM_PREGS));
    if (t1 == OP_REG) begin
        p1 = live_q[rnd(live_q.size())];
    end
    if (t2 == OP_REG) begin
        p2 = live_q[rnd(live_q.size())];
    end
    if (mode == MODE_DEP) begin
        p1 = held_q[rnd(held_q.size())];
    end
    if (t1 == OP_REG) begin
        readers[p1]++;
    end
    if (t2 == OP_REG) begin
        readers[p2]++;
    end
    // Stores keep their random pdst, which the DUT ignores
    if (u != ST) begin
        pd = free_q.pop_front();
        live_q.push_back(pd);
        mpend[pd] = 1'b1;
        if (mode == MODE_LOAD) begin
            held_q.push_back(pd);
        end
    end
    do begin
        rb = RW'(rnd(NUM_ROB));
    end while (r_busy[rb]);
    r_busy[rb]     = 1'b1;
    r_uop[rb]      = u;
    r_t1[rb]       = t1;
    r_t2[rb]       = t2;
    r_p1[rb]       = p1;
    r_p2[rb]       = p2;
    r_pd[rb]       = pd;
    r_imm[rb]      = rand32();
    disp_uop       = u;
    disp_src1_type = t1;
    disp_src2_type = t2;
    disp_psrc1     = p1;
    disp_psrc2     = p2;
    disp_imm       = r_imm[rb];
    disp_pdst      = pd;
    disp_robid     = rb;
    in_flight++;
    ok = 1'b1;
endtask

// Sampled at the falling edge, issues before this cycle's writes
task automatic observe();
    logic [`ISSUE_ROB_W-1:0]  rb;
    logic [`ISSUE_DATA_W-1:0] v1;
    logic [`ISSUE_DATA_W-1:0] v2;
    logic [`ISSUE_DATA_W-1:0] res;
    bit                       is_mem;
    if (ex_iss && mm_iss) begin
        fail_now("ex_iss and mm_iss are high in the same cycle");
    end
    if (ex_iss || mm_iss) begin
        rb = iss_robid;
        if (!r_busy[rb]) begin
            fail_now($sformatf("robid 0x%0h issued but was not waiting to issue", rb));
        end
        is_mem = (r_uop[rb] == LD) || (r_uop[rb] == ST);
        if (mm_iss != is_mem) begin
            fail_now($sformatf("op with robid 0x%0h issued on the wrong port", rb));
        end
        check_uop("iss_uop", iss_uop, r_uop[rb]);
        check_preg("iss_pdst", iss_pdst, r_pd[rb]);
        if ((r_t1[rb] == OP_REG && mpend[r_p1[rb]]) ||
            (r_t2[rb] == OP_REG && mpend[r_p2[rb]])) begin
            fail_now($sformatf("robid 0x%0h issued before its sources were written", rb));
        end
        v1 = operand(r_t1[rb], r_p1[rb], r_imm[rb]);
        v2 = operand(r_t2[rb], r_p2[rb], r_imm[rb]);
        check_data("iss_src1_val", iss_src1_val, v1);
        check_data("iss_src2_val", iss_src2_val, v2);
        if (r_t1[rb] == OP_REG) begin
            readers[r_p1[rb]]--;
        end
        if (r_t2[rb] == OP_REG) begin
            readers[r_p2[rb]]--;
        end
        r_busy[rb] = 1'b0;
        in_flight--;
        n_issued++;
        if (ex_iss) begin
            res = alu_ref(r_uop[rb], v1, v2);
            if (alu_wr_valid !== 1'b1) begin
                fail_now("alu_wr_valid is low while an ALU op issues");
            end
            check_preg("alu_wr_pdst", alu_wr_pdst, r_pd[rb]);
            check_data("alu_wr_data", alu_wr_data, res);
            mval[r_pd[rb]]  = res;
            mpend[r_pd[rb]] = 1'b0;
        end else if (r_uop[rb] == LD) begin
            ld_pd.push_back(r_pd[rb]);
            ld_due.push_back(cyc + 1 + rnd(6));
        end
    end else if (alu_wr_valid !== 1'b0) begin
        fail_now("alu_wr_valid is high with no ALU op issuing");
    end
    if (ext_wr_valid) begin
        mval[ext_wr_pdst]  = ext_wr_data;
        mpend[ext_wr_pdst] = 1'b0;
    end
endtask

task automatic tick(input int mode, output bit sent);
    bit ok;
    @(posedge clk);
    #1;
    cyc++;
    ext_wr_valid = 1'b0;
    if (!hold_loads && ld_pd.size() > 0 && cyc >= ld_due[0]) begin
        ext_wr_valid = 1'b1;
        ext_wr_pdst  = ld_pd.pop_front();
        ext_wr_data  = rand32();
        ld_due.delete(0);
    end
    ok = 1'b0;
    if (mode != MODE_IDLE && !rs_full) begin
        build_op(mode, ok);
    end
    disp_valid = ok;
    sent       = ok;
    @(negedge clk);
    observe();
endtask

task automatic drain();
    bit sent;
    while (in_flight != 0 || ld_pd.size() != 0) begin
        tick(MODE_IDLE, sent);
    end
endtask

initial begin
    #(WD_NS);
    fail_now("watchdog expired before all ops were issued");
end

initial begin
    bit sent;
    int n_sent;
    int n_before;
    rng            = 32'd11447;
    rst_n          = 1'b0;
    disp_valid     = 1'b0;
    disp_uop       = ADD;
    disp_src1_type = OP_ZERO;
    disp_src2_type = OP_ZERO;
    disp_psrc1     = '0;
    disp_psrc2     = '0;
    disp_imm       = '0;
    disp_pdst      = '0;
    disp_robid     = '0;
    ext_wr_valid   = 1'b0;
    ext_wr_pdst    = '0;
    ext_wr_data    = '0;
    hold_loads     = 1'b0;
    in_flight      = 0;
    n_issued       = 0;
    cyc            = 0;
    for (int i = 0; i < `ISSUE_NUM_PREGS; i++) begin
        mval[i]    = '0;
        mpend[i]   = 1'b0;
        readers[i] = 0;
        free_q.push_back(PW'(i));
    end

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (ex_iss || mm_iss || alu_wr_valid || rs_full) begin
        fail_now("issue, writeback or full flag not low after reset");
    end

    // Loads held back, then enough dependents to fill the station
    hold_loads = 1'b1;
    n_sent     = 0;
    while (n_sent < 4) begin
        tick(MODE_LOAD, sent);
        n_sent += int'(sent);
    end
    while (in_flight != 0) begin
        tick(MODE_IDLE, sent);
    end
    n_sent = 0;
    while (n_sent < `ISSUE_RS_ENTS) begin
        tick(MODE_DEP, sent);
        n_sent += int'(sent);
        if (rs_full && in_flight < `ISSUE_RS_ENTS) begin
            fail_now("rs_full went high before the station was full");
        end
    end
    tick(MODE_IDLE, sent);
    if (in_flight == `ISSUE_RS_ENTS && !rs_full) begin
        fail_now("rs_full stayed low with every entry occupied");
    end
    hold_loads = 1'b0;
    n_before   = n_issued;
    while (n_issued == n_before) begin
        tick(MODE_IDLE, sent);
    end
    if (rs_full) begin
        fail_now("rs_full stayed high after an op issued");
    end
    drain();

    n_sent = 0;
    while (n_sent < N_DISP) begin
        tick((rnd(4) == 0) ? MODE_IDLE : MODE_RAND, sent);
        n_sent += int'(sent);
    end
    drain();

    $display("all tests passed");
    $finish;
end

endmodule

`default_nettype wire

// ==== issue_core.f ====
+incdir+.
issue_core_pkg.sv
prf.sv
rs_entry.sv
rs.sv
alu_exec.sv
issue_core.sv
issue_core_assert.sv
issue_core_tb.sv

// ==== Makefile ====
TOP := issue_core_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): issue_core.f *.sv *.svh
	verilator --binary --timing --assert -j 0 -f issue_core.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only --timing -f issue_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir
